//--- flist.f
hdl/index_pkg.sv
hdl/index_operand_alu.sv
hdl/mask_skip_ctrl.sv
hdl/issue_interval_ctrl.sv
hdl/index_unit.sv
hdl/index_gen_top.sv
bench/index_gen_checker.sv
bench/index_gen_tb.sv

//--- bench/index_gen_tb.sv
/* Index generator testbench */

`timescale 1ns/10ps

module index_gen_tb;

	import index_pkg::*;

	localparam int NUM_LANES    = 2;
	localparam int II_CYCLES    = 3;
	localparam int N_SINGLE     = 20;
	localparam int N_SLICE      = 12;    // Requests per slice test
	localparam int SLICE_CYCLES = 100;   // Upper bound for one request
	localparam int MAX_CYCLES   = 10 + N_SINGLE * 8 + 4 * N_SLICE * SLICE_CYCLES + 100;

	typedef logic [10:0] entry_t;   // valid, done, window end, index

	logic      clock = 1'b0;
	logic      reset;
	logic      req, stall, slice, masked, en_ii, swap, sign;
	opnd_sel_e sel_a, sel_b, sel_c;
	index_t    base_idx, window_len, run_len, const_val;
	tid_t      thread_id;
	mask_t     mask;

	logic [NUM_LANES-1:0]   out_valid, out_window_end, busy, done;
	index_t [NUM_LANES-1:0] out_index;

	entry_t exp_q[NUM_LANES][$];   // Expected stream per lane
	integer seed;
	int     sb_errors = 0;
	int     total;

	index_gen_top #(
		.NUM_LANES (NUM_LANES),
		.II_CYCLES (II_CYCLES)
	) dut_i (.*);

	always #20 clock = ~clock;

	function automatic int check_errors();
		return dut_i.g_lane[0].lane_i.chk_i.fail_count + dut_i.g_lane[1].lane_i.chk_i.fail_count;
	endfunction

	// (a * b) +/- c with the forbidden sources read as zero
	function automatic index_t model_index(input index_t orig, input int lane);
		index_t a, b, c, p;
		case (sel_a)
			sel_thread: a = thread_id;
			sel_const:  a = const_val;
			sel_orig:   a = orig;
			default:    a = 8'h00;
		endcase
		case (sel_b)
			sel_const: b = const_val;
			sel_lane:  b = index_t'(lane);
			sel_orig:  b = orig;
			default:   b = 8'h00;
		endcase
		case (sel_c)
			sel_thread: c = thread_id;
			sel_const:  c = const_val;
			sel_lane:   c = index_t'(lane);
			default:    c = orig;
		endcase
		p = a * b;
		if (swap) begin
			return sign ? c - p : c + p;
		end
		return sign ? p - c : p + c;
	endfunction

	// Expected elements of the request now on the inputs
	task automatic predict();
		int last;
		for (int l = 0; l < NUM_LANES; l++) begin
			if (!slice) begin
				exp_q[l].push_back({3'b111, model_index(base_idx, l)});
			end
			else begin
				last = -1;
				for (int k = 0; k < run_len; k++) begin
					if (!masked || mask[k]) last = k;
				end
				if (last < 0) begin
					exp_q[l].push_back({3'b010, 8'h00});   // Empty run
				end
				for (int k = 0; k <= last; k++) begin
					if (!masked || mask[k]) begin
						exp_q[l].push_back({1'b1, k == last,
							((k + 1) % window_len == 0) || k == last,
							model_index(index_t'(base_idx + k), l)});
					end
				end
			end
		end
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	// Kind 0 is a single, 1 a slice, 2 a masked slice, 3 an empty masked slice
	task automatic run_request(input int kind, input bit ii, input bit stalls);
		logic [31:0] r;
		int          cycles;
		@(posedge clock);
		r = $random(seed);
		req        <= 1'b1;
		stall      <= 1'b0;
		slice      <= kind != 0;
		masked     <= kind >= 2;
		en_ii      <= ii;
		sel_a      <= opnd_sel_e'(r[1:0]);
		sel_b      <= opnd_sel_e'(r[3:2]);
		sel_c      <= opnd_sel_e'(r[5:4]);
		swap       <= r[6];
		sign       <= r[7];
		base_idx   <= r[15:8];
		run_len    <= index_t'(r[20:16]) + 8'd1;
		window_len <= index_t'(r[23:21]) + 8'd1;
		thread_id  <= r[31:24];
		const_val  <= index_t'($random(seed));
		mask       <= (kind == 3) ? '0 : mask_t'($random(seed));
		@(negedge clock);
		predict();
		cycles = 0;
		do begin
			@(posedge clock);
			if (stalls && cycles == 0) begin   // Second request while the lane is busy
				req      <= 1'b1;
				stall    <= 1'b0;
				base_idx <= base_idx + 8'd1;
			end
			else begin
				req   <= 1'b0;
				stall <= stalls && ($random(seed) % 4 == 0);
			end
			@(negedge clock);
			cycles++;
		end while (busy != '0 && cycles < SLICE_CYCLES);
		if (busy != '0) begin
			sb_errors++;
			$display("Lanes stayed busy past the cycle limit at %0t", $time);
		end
	endtask

	initial begin
		seed  = 32'h4717;
		reset = 1'b1;
		req   = 1'b0;
		stall = 1'b0;
		slice = 1'b0;
		masked = 1'b0;
		en_ii = 1'b0;
		sel_a = sel_thread;
		sel_b = sel_const;
		sel_c = sel_orig;
		swap = 1'b0;
		sign = 1'b0;
		base_idx = '0;
		window_len = 8'd1;
		run_len = 8'd1;
		thread_id = '0;
		const_val = '0;
		mask = '0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;

		for (int i = 0; i < N_SINGLE; i++) run_request(0, 1'b0, 1'b0);
		for (int i = 0; i < N_SLICE; i++) run_request(1, 1'b0, 1'b0);
		for (int i = 0; i < N_SLICE; i++) run_request(i == 0 ? 3 : 2, 1'b0, 1'b0);
		for (int i = 0; i < N_SLICE; i++) run_request(1 + i % 2, 1'b0, 1'b1);
		for (int i = 0; i < N_SLICE; i++) run_request(1 + i % 3, 1'b1, i[0]);

		repeat (4) @(posedge clock);
		for (int l = 0; l < NUM_LANES; l++) begin
			if (exp_q[l].size() != 0) begin
				sb_errors++;
				$display("Lane %0d never produced %0d expected outputs", l, exp_q[l].size());
			end
		end
		total = sb_errors + check_errors();
		$display("Errors: scoreboard %0d, assertions %0d", sb_errors, check_errors());
		if (total == 0) begin
			$display("Simulation PASSED");
		end
		else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	//////////////////////////////
	// Scoreboard and watchdog
	//////////////////////////////

	always @(negedge clock) begin
		entry_t got;
		entry_t want;
		if (!reset) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				if (out_valid[l] || done[l] || out_window_end[l]) begin
					got = {out_valid[l], done[l], out_window_end[l],
						out_valid[l] ? out_index[l] : 8'h00};
					if (exp_q[l].size() == 0) begin
						sb_errors++;
						$display("Lane %0d gave an output with none expected at %0t", l, $time);
					end
					else begin
						want = exp_q[l].pop_front();
						// Flags are valid, done and window end
						assert (got == want) else begin
							sb_errors++;
							$display("Mismatch at %0t: lane %0d got %b %h, expected %b %h",
								$time, l, got[10:8], got[7:0], want[10:8], want[7:0]);
						end
					end
				end
			end
		end
	end

	initial begin
		#(MAX_CYCLES * 40);
		$display("Watchdog expired before the tests finished");
		$display("Errors: scoreboard %0d, assertions %0d", sb_errors, check_errors());
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- bench/index_gen_checker.sv
/* Lane protocol assertions */

`timescale 1ns/10ps

module index_gen_checker #(
	parameter int II_CYCLES = index_pkg::default_ii_cycles
) (
	input logic clock,
	input logic reset,
	input logic req,
	input logic stall,
	input logic slice,
	input logic en_ii,
	input logic out_valid,
	input logic out_window_end,
	input logic busy,
	input logic done
);

	int   fail_count = 0;
	int   gap_left;        // Gap cycles still owed
	logic armed;           // Current slice was issued with en_ii
	logic idle_due;        // Busy must be low this cycle
	logic accept;

	assign accept = req & ~stall & ~busy;

	always_ff @(posedge clock) begin
		if (reset) begin
			armed    <= 1'b0;
			gap_left <= 0;
			idle_due <= 1'b0;
		end
		else begin
			if (accept) begin
				armed <= slice & en_ii;
			end
			if (done) begin   // Already masked by stall
				gap_left <= armed ? II_CYCLES : 0;
			end
			else if (gap_left != 0 && !stall) begin
				gap_left <= gap_left - 1;
			end
			idle_due <= (done && (!armed || II_CYCLES == 0)) || (gap_left == 1 && !stall);
		end
	end

	//////////////////////////////
	// Protocol properties
	//////////////////////////////

	reset_quiet: assert property (@(posedge clock)
		reset |=> !busy && !out_valid && !done && !out_window_end)
		else begin
			fail_count++;
			$error("Outputs or busy active right after reset");
		end

	stall_quiet: assert property (@(posedge clock) disable iff (reset)
		stall |-> !out_valid && !done && !out_window_end)
		else begin
			fail_count++;
			$error("Output shown while stall is high");
		end

	first_output: assert property (@(posedge clock) disable iff (reset)
		accept |=> stall || out_valid || done)
		else begin
			fail_count++;
			$error("No output in the cycle after an accepted request");
		end

	gap_busy: assert property (@(posedge clock) disable iff (reset)
		gap_left != 0 |-> busy)
		else begin
			fail_count++;
			$error("Busy dropped during the initiation-interval gap");
		end

	gap_release: assert property (@(posedge clock) disable iff (reset)
		idle_due |-> !busy)
		else begin
			fail_count++;
			$error("Busy still high after the request and its gap ended");
		end

endmodule

bind index_unit index_gen_checker #(
	.II_CYCLES (II_CYCLES)
) chk_i (
	.clock          (clock),
	.reset          (reset),
	.req            (req),
	.stall          (stall),
	.slice          (slice),
	.en_ii          (en_ii),
	.out_valid      (out_valid),
	.out_window_end (out_window_end),
	.busy           (busy),
	.done           (done)
);

//--- hdl/index_gen_top.sv
/* Two-lane index generator */

`timescale 1ns/10ps

module index_gen_top #(
	parameter int NUM_LANES = index_pkg::default_num_lanes,
	parameter int II_CYCLES = index_pkg::default_ii_cycles
) (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic                                  req,
	input  logic                                  stall,
	input  logic                                  slice,
	input  logic                                  masked,
	input  logic                                  en_ii,
	input  index_pkg::opnd_sel_e                  sel_a,
	input  index_pkg::opnd_sel_e                  sel_b,
	input  index_pkg::opnd_sel_e                  sel_c,
	input  logic                                  swap,
	input  logic                                  sign,
	input  index_pkg::index_t                     base_idx,
	input  index_pkg::index_t                     window_len,
	input  index_pkg::index_t                     run_len,
	input  index_pkg::tid_t                       thread_id,
	input  index_pkg::index_t                     const_val,
	input  index_pkg::mask_t                      mask,
	output logic [NUM_LANES-1:0]                  out_valid,
	output index_pkg::index_t [NUM_LANES-1:0]     out_index,
	output logic [NUM_LANES-1:0]                  out_window_end,
	output logic [NUM_LANES-1:0]                  busy,
	output logic [NUM_LANES-1:0]                  done
);

	import index_pkg::*;

	// Issue fields fan out to every lane, each with its own id
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		index_unit #(
			.LANE_ID   (lane_id_t'(i)),
			.II_CYCLES (II_CYCLES)
		) lane_i (
			.clock          (clock),
			.reset          (reset),
			.req            (req),
			.stall          (stall),
			.slice          (slice),
			.masked         (masked),
			.en_ii          (en_ii),
			.sel_a          (sel_a),
			.sel_b          (sel_b),
			.sel_c          (sel_c),
			.swap           (swap),
			.sign           (sign),
			.base_idx       (base_idx),
			.window_len     (window_len),
			.run_len        (run_len),
			.thread_id      (thread_id),
			.const_val      (const_val),
			.mask           (mask),
			.out_valid      (out_valid[i]),
			.out_index      (out_index[i]),
			.out_window_end (out_window_end[i]),
			.busy           (busy[i]),
			.done           (done[i])
		);
	end

endmodule

//--- hdl/index_unit.sv
/* Index generation lane */

`timescale 1ns/10ps

module index_unit #(
	parameter index_pkg::lane_id_t LANE_ID = '0,
	parameter int II_CYCLES = index_pkg::default_ii_cycles
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 req,
	input  logic                 stall,
	input  logic                 slice,
	input  logic                 masked,
	input  logic                 en_ii,
	input  index_pkg::opnd_sel_e sel_a,
	input  index_pkg::opnd_sel_e sel_b,
	input  index_pkg::opnd_sel_e sel_c,
	input  logic                 swap,
	input  logic                 sign,
	input  index_pkg::index_t    base_idx,
	input  index_pkg::index_t    window_len,
	input  index_pkg::index_t    run_len,
	input  index_pkg::tid_t      thread_id,
	input  index_pkg::index_t    const_val,
	input  index_pkg::mask_t     mask,
	output logic                 out_valid,
	output index_pkg::index_t    out_index,
	output logic                 out_window_end,
	output logic                 busy,
	output logic                 done
);

	import index_pkg::*;

	lane_state_e state;
	logic        ii_q;           // Slice was issued with en_ii
	logic        run_st;
	logic        accept;
	logic        active;         // An element step happens this cycle
	logic        slice_path;
	logic        emit;
	logic        last;
	logic        wrap;
	logic        hold;

	// Request fields held for the rest of a slice
	opnd_sel_e   sel_a_q, sel_b_q, sel_c_q;
	logic        swap_q, sign_q;
	tid_t        tid_q;
	index_t      const_q, base_q, window_q;

	index_t      pos_q;          // Next candidate position
	index_t      next_offset;
	index_t      elem_next;
	index_t      cur_base;
	index_t      cur_window;
	index_t      alu_result;
	logic        found, run_end;

	// Output register
	logic        valid_q, win_q, done_q;
	index_t      index_q;

	assign run_st     = (state == run);
	assign busy       = run_st | done_q | hold;
	assign accept     = req & ~stall & ~busy;
	assign active     = accept | (run_st & ~stall);
	assign slice_path = run_st | slice;

	assign cur_base   = run_st ? base_q : base_idx;
	assign cur_window = run_st ? window_q : window_len;
	assign elem_next  = next_offset + 1'b1;

	// A non-slice request is a single, final element
	assign emit = slice_path ? found : 1'b1;
	assign last = slice_path ? run_end : 1'b1;
	assign wrap = (elem_next % cur_window) == '0;

	//////////////////////////////
	// Lane FSM
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			ii_q  <= 1'b0;
		end
		else if (accept) begin
			ii_q <= en_ii;
			if (!slice) begin
				state <= idle;
			end
			else if (!run_end) begin
				state <= run;
			end
			else begin
				state <= en_ii ? gap : idle;   // One-element or empty slice
			end
		end
		else begin
			case (state)
				run: begin
					if (!stall && run_end) begin
						state <= ii_q ? gap : idle;
					end
				end
				gap: begin
					if (!done_q && !hold) begin
						state <= idle;
					end
				end
				default: state <= state;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			sel_a_q  <= sel_a;
			sel_b_q  <= sel_b;
			sel_c_q  <= sel_c;
			swap_q   <= swap;
			sign_q   <= sign;
			tid_q    <= thread_id;
			const_q  <= const_val;
			base_q   <= base_idx;
			window_q <= window_len;
		end
		if (active && slice_path) begin
			pos_q <= elem_next;   // Search resumes past this element
		end
	end

	//////////////////////////////
	// Output stage
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
			win_q   <= 1'b0;
			done_q  <= 1'b0;
		end
		else if (!stall) begin
			valid_q <= active & emit;
			win_q   <= active & emit & (last | wrap);
			done_q  <= active & last;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			index_q <= alu_result;
		end
	end

	// Held element is shown again once stall drops
	assign out_valid      = valid_q & ~stall;
	assign out_window_end = win_q & ~stall;
	assign done           = done_q & ~stall;
	assign out_index      = index_q;

	index_operand_alu alu_i (
		.sel_a     (run_st ? sel_a_q : sel_a),
		.sel_b     (run_st ? sel_b_q : sel_b),
		.sel_c     (run_st ? sel_c_q : sel_c),
		.swap      (run_st ? swap_q : swap),
		.sign      (run_st ? sign_q : sign),
		.thread_id (run_st ? tid_q : thread_id),
		.const_val (run_st ? const_q : const_val),
		.orig_idx  (slice_path ? cur_base + next_offset : cur_base),
		.lane_id   (LANE_ID),
		.result    (alu_result)
	);

	mask_skip_ctrl skip_i (
		.clock       (clock),
		.reset       (reset),
		.load        (accept & slice),
		.masked      (masked),
		.mask        (mask),
		.run_len     (run_len),
		.position    (run_st ? pos_q : index_t'(0)),
		.next_offset (next_offset),
		.found       (found),
		.run_end     (run_end)
	);

	issue_interval_ctrl #(
		.II_CYCLES (II_CYCLES)
	) ii_i (
		.clock     (clock),
		.reset     (reset),
		.stall     (stall),
		.arm       (accept & slice & en_ii),
		.slice_end (done_q & ~stall),   // Gap starts after done is taken
		.hold      (hold)
	);

endmodule

//--- hdl/issue_interval_ctrl.sv
/* Initiation-interval gap */

`timescale 1ns/10ps

module issue_interval_ctrl #(
	parameter int II_CYCLES = index_pkg::default_ii_cycles
) (
	input  logic clock,
	input  logic reset,
	input  logic stall,
	input  logic arm,
	input  logic slice_end,
	output logic hold
);

	import index_pkg::*;

	localparam int CW = $clog2(II_CYCLES + 2);

	lane_state_e    state;   // run means armed and waiting
	logic [CW-1:0]  count;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			count <= '0;
		end
		else begin
			case (state)
				idle: begin
					if (arm) begin
						state <= run;
					end
				end
				run: begin
					if (slice_end) begin
						count <= CW'(II_CYCLES);
						state <= (II_CYCLES > 0) ? gap : idle;
					end
				end
				gap: begin
					if (!stall) begin   // Stall freezes the gap
						count <= count - 1'b1;
						if (count == CW'(1)) begin
							state <= idle;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	assign hold = (state == gap);

endmodule

//--- hdl/mask_skip_ctrl.sv
/* Mask skip controller */

`timescale 1ns/10ps

module mask_skip_ctrl (
	input  logic               clock,
	input  logic               reset,
	input  logic               load,
	input  logic               masked,
	input  index_pkg::mask_t   mask,
	input  index_pkg::index_t  run_len,
	input  index_pkg::index_t  position,
	output index_pkg::index_t  next_offset,
	output logic               found,
	output logic               run_end
);

	import index_pkg::*;

	localparam int MW = $bits(mask_t);

	mask_t  mask_q;     // Mask limited to the run
	index_t len_q;
	logic   masked_q;

	mask_t  src_mask;
	index_t src_len;
	logic   src_masked;
	mask_t  in_run;     // Positions below the run length
	mask_t  at_or_above;
	mask_t  cand;

	// The request cycle searches the incoming fields directly
	assign src_len    = load ? run_len : len_q;
	assign src_masked = load ? masked : masked_q;
	assign src_mask   = load ? (mask & in_run) : mask_q;

	always_comb begin
		for (int i = 0; i < MW; i++) begin
			in_run[i]      = (i < int'(src_len));
			at_or_above[i] = (i >= int'(position));
		end
	end

	// Every position of the run is a candidate when unmasked
	assign cand = (src_masked ? src_mask : in_run) & at_or_above;

	//////////////////////////////
	// Lowest set bit
	//////////////////////////////

	always_comb begin
		next_offset = '0;
		found       = 1'b0;
		run_end     = 1'b1;
		for (int i = 0; i < MW; i++) begin
			if (cand[i] && !found) begin
				next_offset = index_t'(i);
				found       = 1'b1;
			end
			else if (cand[i]) begin
				run_end = 1'b0;   // A later element remains
			end
		end
	end

	//////////////////////////////
	// Request capture
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			masked_q <= 1'b0;
		end
		else if (load) begin
			masked_q <= masked;
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			mask_q <= mask & in_run;   // Bits at or above run_len cleared
			len_q  <= run_len;
		end
	end

endmodule

//--- hdl/index_operand_alu.sv
/* Index operand ALU */

`timescale 1ns/10ps

module index_operand_alu (
	input  index_pkg::opnd_sel_e sel_a,
	input  index_pkg::opnd_sel_e sel_b,
	input  index_pkg::opnd_sel_e sel_c,
	input  logic                 swap,
	input  logic                 sign,
	input  index_pkg::tid_t      thread_id,
	input  index_pkg::index_t    const_val,
	input  index_pkg::index_t    orig_idx,
	input  index_pkg::lane_id_t  lane_id,
	output index_pkg::index_t    result
);

	import index_pkg::*;

	index_t opnd_a;
	index_t opnd_b;
	index_t opnd_c;
	index_t lane_val;
	index_t product;
	index_t left;
	index_t right;

	assign lane_val = index_t'(lane_id);   // Zero extended

	//////////////////////////////
	// Operand muxes
	//////////////////////////////

	always_comb begin
		case (sel_a)
			sel_thread: opnd_a = thread_id;
			sel_const:  opnd_a = const_val;
			sel_orig:   opnd_a = orig_idx;
			default:    opnd_a = '0;   // No lane source for a
		endcase
	end

	always_comb begin
		case (sel_b)
			sel_const: opnd_b = const_val;
			sel_lane:  opnd_b = lane_val;
			sel_orig:  opnd_b = orig_idx;
			default:   opnd_b = '0;   // No thread source for b
		endcase
	end

	always_comb begin
		case (sel_c)
			sel_thread: opnd_c = thread_id;
			sel_const:  opnd_c = const_val;
			sel_lane:   opnd_c = lane_val;
			default:    opnd_c = orig_idx;
		endcase
	end

	//////////////////////////////
	// Multiply, order, add
	//////////////////////////////

	// Product kept modulo 256
	assign product = index_t'(opnd_a * opnd_b);

	// Swap puts c on the left of the subtraction
	assign left  = swap ? opnd_c : product;
	assign right = swap ? product : opnd_c;

	assign result = sign ? (left - right) : (left + right);

endmodule

//--- hdl/index_pkg.sv
/* Index generation types */

package index_pkg;

	//////////////////////////////
	// Data widths
	//////////////////////////////

	// Element or register-file index
	typedef logic [7:0] index_t;

	// One mask bit per element of a slice run
	typedef logic [31:0] mask_t;

	typedef logic [7:0] tid_t;       // Thread id
	typedef logic [1:0] lane_id_t;   // Lane id within the group

	//////////////////////////////
	// Operand sources
	//////////////////////////////

	// Operand a has no lane source, operand b has no thread source
	typedef enum logic [1:0] {
		sel_thread = 2'd0,
		sel_const  = 2'd1,
		sel_lane   = 2'd2,
		sel_orig   = 2'd3
	} opnd_sel_e;

	//////////////////////////////
	// Lane control
	//////////////////////////////

	// Shared by the lane FSM and the interval counter
	typedef enum logic [1:0] {
		idle = 2'd0,
		run  = 2'd1,
		gap  = 2'd2
	} lane_state_e;

	// Defaults for the top-level parameters
	localparam int default_ii_cycles = 3;   // Initiation-interval gap length
	localparam int default_num_lanes = 2;   // Lanes in the group

endpackage
